// ==== eg_top.f ====
+incdir+tb
common/eg_pkg.sv
common/eg_slot_if.sv
hw/eg_timebase.sv
envelope/eg_phase_sel.sv
envelope/eg_rate_step.sv
envelope/eg_level_calc.sv
envelope/eg_slot_ring.sv
hw/eg_top.sv
tb/eg_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the envelope generator testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary -Wno-fatal --top-module eg_tb -f eg_top.f -o eg_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see $build_log"
	exit 1
fi

./obj_dir/eg_sim > "$sim_log" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status, see $sim_log"
	exit 1
fi

if grep -qx "SIMULATION PASSED" "$sim_log"; then
	echo "run passed"
	exit 0
else
	echo "pass line missing from $sim_log"
	exit 1
fi

// ==== tb/eg_ref_model.svh ====
/*
	Envelope reference model for all 24 slots.
	Own copy of the time base, per-slot state and a queue
	of expected levels eg_latency enabled cycles deep.
*/
`ifndef EG_REF_MODEL_SVH
`define EG_REF_MODEL_SVH

logic [eg_pkg::level_w-1:0] ref_level [eg_pkg::num_slots]; // stored attenuation
logic [1:0]                 ref_phase [eg_pkg::num_slots];
logic                       ref_key   [eg_pkg::num_slots];
logic                       ref_cbit  [eg_pkg::num_slots]; // counter bit of last pass
logic [eg_pkg::level_w-1:0] lvl_fifo  [$];
logic [eg_pkg::level_w-1:0] exp_level;
logic                       exp_rst;
logic [eg_pkg::slot_w-1:0]  exp_slot;
int unsigned                ref_edges; // enabled cycles since reset

// global counter, one tick per three samples
function automatic logic [eg_pkg::cnt_w-1:0] env_count(input int unsigned edges);
	return eg_pkg::cnt_w'(edges / (3 * eg_pkg::num_slots));
endfunction

task automatic reset_model();
	for (int i = 0; i < eg_pkg::num_slots; i++) begin
		ref_level[i] = eg_pkg::level_max; // silent, released, key up
		ref_phase[i] = eg_pkg::ph_release;
		ref_key[i]   = 1'b0;
		ref_cbit[i]  = 1'b0;
	end
	lvl_fifo.delete();
	ref_edges = 0;
	exp_level = eg_pkg::level_max;
	exp_rst   = 1'b0;
	exp_slot  = '0;
endtask

// one slot, inputs as sampled on the enabled edge just passed
task automatic step_model();
	int         s;
	int         lvl;
	int         raw;
	int         rate;
	int         grp;
	int         start;
	int         sel;
	int         delta;
	int         amv;
	int         att;
	logic       on_edge;
	logic       off_edge;
	logic       step;
	logic [1:0] ph;
	logic [7:0] pat;
	s        = int'(ref_edges % eg_pkg::num_slots);
	lvl      = int'(ref_level[s]);
	ph       = ref_phase[s];
	on_edge  = keyon & ~ref_key[s];
	off_edge = ~keyon & ref_key[s];
	exp_rst  = on_edge | (lvl == int'(eg_pkg::level_max));

	////////////////////////////////////////////////////////////////////////////
	// phase walk and raw rate
	if (off_edge) begin
		ph  = eg_pkg::ph_release;
		raw = 2 * int'(rrate) + 1;
	end else if (on_edge) begin
		ph  = eg_pkg::ph_attack;
		raw = int'(arate);
	end else begin
		case (ph)
			eg_pkg::ph_attack: begin
				raw = (lvl == 0) ? int'(drate1) : int'(arate);
				if (lvl == 0)
					ph = eg_pkg::ph_decay1; // peak
			end
			eg_pkg::ph_decay1: begin
				raw = int'(drate1);
				if ((lvl >> 5) >= ((sus_level == 4'hf) ? 31 : int'(sus_level))) begin
					ph  = eg_pkg::ph_decay2;
					raw = int'(drate2);
				end
			end
			eg_pkg::ph_decay2: raw = int'(drate2);
			default:           raw = 2 * int'(rrate) + 1;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// key scaled rate and step decision
	rate  = (raw == 0) ? 0 : 2 * raw + (int'(keycode) >> (3 - int'(key_scale)));
	rate  = (rate > 63) ? 63 : rate;
	grp   = rate >> 2;
	start = ((ph == eg_pkg::ph_attack) ? 11 : 12) - grp;
	start = (start < 0) ? 0 : start;
	sel   = int'(env_count(ref_edges + 2) >> start) & 7; // counter seen two cycles on
	if (grp >= 12)
		pat = (grp == 15 && ph == eg_pkg::ph_attack) ? eg_pkg::step_pat_full
		                                              : eg_pkg::step_pat_hi[rate % 4];
	else
		pat = (grp == 0 && ph != eg_pkg::ph_attack) ? eg_pkg::step_pat_slow
		                                             : eg_pkg::step_pat_lo[rate % 4];
	step = (rate >= 2) && pat[sel] && ((sel % 2) != int'(ref_cbit[s]));

	////////////////////////////////////////////////////////////////////////////
	// level arithmetic
	if (on_edge && arate == 5'd31) begin
		lvl = 0; // attack off
	end else if (ph == eg_pkg::ph_attack) begin
		if (step && rate >= 62) begin
			lvl = 0;
		end else if (step) begin
			delta = (lvl >> ((grp == 13) ? 3 : (grp >= 14) ? 2 : 4)) + 1;
			lvl   = (delta < lvl) ? lvl - delta : 0;
		end
	end else if (step) begin
		lvl = lvl + ((grp < 12) ? 1 : (1 << (grp - 12)));
		lvl = (lvl > int'(eg_pkg::level_max)) ? int'(eg_pkg::level_max) : lvl;
	end
	ref_level[s] = eg_pkg::level_w'(lvl);
	ref_phase[s] = ph;
	ref_key[s]   = keyon;
	ref_cbit[s]  = 1'(sel % 2);

	// total attenuation
	amv = 0;
	if (ams_en && ams != 2'd0)
		amv = int'(am) << (int'(ams) - 1);
	att = lvl + 8 * int'(tl) + 2 * amv;
	att = (att > int'(eg_pkg::level_max)) ? int'(eg_pkg::level_max) : att;
	lvl_fifo.push_back(eg_pkg::level_w'(att));
	if (lvl_fifo.size() == eg_pkg::eg_latency)
		exp_level = lvl_fifo.pop_front();
	ref_edges++;
	exp_slot = eg_pkg::slot_w'(ref_edges % eg_pkg::num_slots);
endtask

`endif

// ==== tb/eg_tb.sv ====
/*
	Envelope generator testbench.
	Plays the per-slot register file with random settings and key
	events, random clk_en gaps, checks every output against the model.
*/
`timescale 1ns/1ps

module eg_tb;

	localparam int     num_samples = 8000;
	localparam int     run_edges   = num_samples * eg_pkg::num_slots;
	localparam longint watchdog_ns = longint'(num_samples) * eg_pkg::num_slots * 10 * 2;

	logic                       clk;
	logic                       rst;
	logic                       clk_en;
	logic                       keyon;
	logic [4:0]                 arate;
	logic [4:0]                 drate1;
	logic [4:0]                 drate2;
	logic [4:0]                 keycode;
	logic [3:0]                 rrate;
	logic [3:0]                 sus_level;
	logic [1:0]                 key_scale;
	logic [1:0]                 ams;
	logic [eg_pkg::tl_w-1:0]    tl;
	logic [eg_pkg::am_w-1:0]    am;
	logic                       ams_en;
	logic [eg_pkg::slot_w-1:0]  slot;
	logic [eg_pkg::level_w-1:0] eg_level;
	logic                       phase_rst;
	logic                       en_prev; // last rising edge was enabled

	// register file, one entry per slot
	logic                    reg_keyon   [eg_pkg::num_slots];
	logic [4:0]              reg_arate   [eg_pkg::num_slots];
	logic [4:0]              reg_drate1  [eg_pkg::num_slots];
	logic [4:0]              reg_drate2  [eg_pkg::num_slots];
	logic [3:0]              reg_rrate   [eg_pkg::num_slots];
	logic [3:0]              reg_sus     [eg_pkg::num_slots];
	logic [4:0]              reg_keycode [eg_pkg::num_slots];
	logic [1:0]              reg_kscale  [eg_pkg::num_slots];
	logic [eg_pkg::tl_w-1:0] reg_tl      [eg_pkg::num_slots];
	logic [eg_pkg::am_w-1:0] reg_am      [eg_pkg::num_slots];
	logic [1:0]              reg_ams     [eg_pkg::num_slots];
	logic                    reg_amsen   [eg_pkg::num_slots];

	`include "eg_ref_model.svh"

	eg_top dut0 (.*);

	always #5 clk = ~clk;

	// new settings and key state for one slot, biased to rates that finish
	task automatic program_slot(input int s);
		reg_keyon[s]   = ($urandom % 4) != 0;
		reg_arate[s]   = ($urandom % 6 == 0) ? 5'd31 : 5'($urandom_range(31, 18));
		reg_drate1[s]  = 5'($urandom_range(31, 24));
		reg_drate2[s]  = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom_range(31, 20)); // 0 holds
		reg_rrate[s]   = 4'($urandom % 16);
		reg_sus[s]     = ($urandom % 3 == 0) ? 4'hf : 4'($urandom % 16);
		reg_keycode[s] = 5'($urandom % 32);
		reg_kscale[s]  = 2'($urandom % 4);
		reg_tl[s]      = ($urandom % 3 == 0) ? 7'd0 : 7'($urandom % 128);
		reg_am[s]      = 7'($urandom % 128);
		reg_ams[s]     = 2'($urandom % 4);
		reg_amsen[s]   = 1'($urandom % 2);
	endtask

	// settings of the slot the DUT is about to sample
	task automatic drive_inputs();
		int s;
		s         = int'(slot);
		clk_en    = ($urandom % 8) != 0; // about one gap in eight
		keyon     = reg_keyon[s];
		arate     = reg_arate[s];
		drate1    = reg_drate1[s];
		drate2    = reg_drate2[s];
		rrate     = reg_rrate[s];
		sus_level = reg_sus[s];
		keycode   = reg_keycode[s];
		key_scale = reg_kscale[s];
		tl        = reg_tl[s];
		am        = reg_am[s];
		ams       = reg_ams[s];
		ams_en    = reg_amsen[s];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	task automatic check_level(input logic [eg_pkg::level_w-1:0] got,
	                           input logic [eg_pkg::level_w-1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: eg_level is %0d, expected %0d", $time, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "eg_level mismatch");
		end
	endtask

	task automatic check_phase_rst(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: phase_rst is %b, expected %b", $time, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "phase_rst mismatch");
		end
	endtask

	task automatic check_slot(input logic [eg_pkg::slot_w-1:0] got,
	                          input logic [eg_pkg::slot_w-1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: slot is %0d, expected %0d", $time, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "slot mismatch");
		end
	endtask

	initial begin
		#(watchdog_ns);
		$display("timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(32'hbcaf3df8)); // seeds the generator once
		clk       = 1'b0;
		rst       = 1'b1;
		clk_en    = 1'b0;
		keyon     = 1'b0;
		arate     = '0;
		drate1    = '0;
		drate2    = '0;
		rrate     = '0;
		sus_level = '0;
		keycode   = '0;
		key_scale = '0;
		tl        = '0;
		am        = '0;
		ams       = '0;
		ams_en    = 1'b0;
		en_prev   = 1'b0;
		for (int s = 0; s < eg_pkg::num_slots; s++)
			program_slot(s);
		reset_model();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// outputs are stable here, half a cycle after the rising edge
		while (ref_edges < run_edges) begin
			if (en_prev)
				step_model();
			check_slot(slot, exp_slot);
			check_level(eg_level, exp_level);
			check_phase_rst(phase_rst, exp_rst);
			if ($urandom % 800 == 0)
				program_slot(int'($urandom % eg_pkg::num_slots)); // key event
			drive_inputs();
			en_prev = clk_en;
			@(negedge clk);
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== hw/eg_top.sv ====
/*
	Envelope generator top level.
	24 operator slots time-multiplexed through three stages,
	per-slot state kept in the slot ring.
*/
`timescale 1ns/1ps

module eg_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       clk_en,
	input  logic                       keyon,
	input  logic [4:0]                 arate,
	input  logic [4:0]                 drate1,
	input  logic [4:0]                 drate2,
	input  logic [3:0]                 rrate,
	input  logic [3:0]                 sus_level,
	input  logic [4:0]                 keycode,
	input  logic [1:0]                 key_scale,
	input  logic [eg_pkg::tl_w-1:0]    tl,
	input  logic [eg_pkg::am_w-1:0]    am,
	input  logic [1:0]                 ams,
	input  logic                       ams_en,
	output logic [eg_pkg::slot_w-1:0]  slot,
	output logic [eg_pkg::level_w-1:0] eg_level,
	output logic                       phase_rst
);

	logic [eg_pkg::cnt_w-1:0]   eg_cnt;
	logic [eg_pkg::level_w-1:0] ring_level;
	logic [1:0]                 ring_phase;
	logic                       ring_key;
	logic                       ring_cnt_bit;
	logic                       key_now;
	logic                       cnt_bit;
	logic [eg_pkg::level_w-1:0] new_level;
	logic [1:0]                 new_phase;

	eg_slot_if ph2rt ();
	eg_slot_if rt2lv ();

	eg_timebase u_timebase (
		.clk (clk), .rst (rst), .clk_en (clk_en),
		.slot (slot), .sample_zero (), .eg_cnt (eg_cnt)
	);

	eg_phase_sel u_phase_sel (
		.clk (clk), .rst (rst), .clk_en (clk_en),
		.keyon (keyon), .arate (arate), .drate1 (drate1), .drate2 (drate2),
		.rrate (rrate), .sus_level (sus_level),
		.ring_level (ring_level), .ring_phase (ring_phase), .ring_key (ring_key),
		.key_now (key_now), .phase_rst (phase_rst), .ph2rt (ph2rt.src)
	);

	eg_rate_step u_rate_step (
		.clk (clk), .rst (rst), .clk_en (clk_en),
		.keycode (keycode), .key_scale (key_scale), .eg_cnt (eg_cnt),
		.ring_cnt_bit (ring_cnt_bit), .ph2rt (ph2rt.dst), .rt2lv (rt2lv.src),
		.cnt_bit (cnt_bit)
	);

	eg_level_calc u_level_calc (
		.clk (clk), .rst (rst), .clk_en (clk_en),
		.tl (tl), .am (am), .ams (ams), .ams_en (ams_en), .rt2lv (rt2lv.dst),
		.new_level (new_level), .new_phase (new_phase), .eg_level (eg_level)
	);

	eg_slot_ring u_slot_ring (
		.clk (clk), .rst (rst), .clk_en (clk_en),
		.level_in (new_level), .phase_in (new_phase),
		.key_in (key_now), .cnt_bit_in (cnt_bit),
		.level_out (ring_level), .phase_out (ring_phase),
		.key_out (ring_key), .cnt_bit_out (ring_cnt_bit)
	);

endmodule

// ==== envelope/eg_slot_ring.sv ====
/*
	Per-slot envelope storage as a circulating shift ring.
	Level and phase return after ring_depth enabled cycles,
	key and counter bits one slot short of a full pass.
*/
`timescale 1ns/1ps

module eg_slot_ring (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       clk_en,
	input  logic [eg_pkg::level_w-1:0] level_in,
	input  logic [1:0]                 phase_in,
	input  logic                       key_in,
	input  logic                       cnt_bit_in,
	output logic [eg_pkg::level_w-1:0] level_out,
	output logic [1:0]                 phase_out,
	output logic                       key_out,
	output logic                       cnt_bit_out
);

	logic [eg_pkg::level_w+1:0] lp_sh [eg_pkg::ring_depth];   // level, phase
	logic [1:0]                 kc_sh [eg_pkg::num_slots-1]; // key, counter bit

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < eg_pkg::ring_depth; i++)
				lp_sh[i] <= {eg_pkg::level_max, eg_pkg::ph_release}; // silent slot
			for (int i = 0; i < eg_pkg::num_slots - 1; i++)
				kc_sh[i] <= '0;
		end else if (clk_en) begin
			lp_sh[0] <= {level_in, phase_in};
			kc_sh[0] <= {key_in, cnt_bit_in};
			for (int i = 1; i < eg_pkg::ring_depth; i++)
				lp_sh[i] <= lp_sh[i-1];
			for (int i = 1; i < eg_pkg::num_slots - 1; i++)
				kc_sh[i] <= kc_sh[i-1];
		end
	end

	assign {level_out, phase_out} = lp_sh[eg_pkg::ring_depth-1];
	assign {key_out, cnt_bit_out} = kc_sh[eg_pkg::num_slots-2];

endmodule

// ==== envelope/eg_level_calc.sv ====
/*
	Envelope stage three.
	Cycle one applies the exponential attack or linear decay step.
	Cycle two adds total level and scaled AM, clamps to silence.
*/
`timescale 1ns/1ps

module eg_level_calc (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       clk_en,
	input  logic [eg_pkg::tl_w-1:0]    tl,
	input  logic [eg_pkg::am_w-1:0]    am,
	input  logic [1:0]                 ams,
	input  logic                       ams_en,
	eg_slot_if.dst                     rt2lv,
	output logic [eg_pkg::level_w-1:0] new_level,
	output logic [1:0]                 new_phase,
	output logic [eg_pkg::level_w-1:0] eg_level
);

	logic [eg_pkg::tl_w+eg_pkg::am_w+2:0] set_d [4]; // settings follow the slot
	logic [eg_pkg::tl_w-1:0]    tl_d;
	logic [eg_pkg::am_w-1:0]    am_d;
	logic [1:0]                 ams_d;
	logic                       ams_en_d;
	logic [eg_pkg::level_w-1:0] ar_delta;
	logic [eg_pkg::level_w:0]   dec_inc;
	logic [eg_pkg::level_w:0]   dec_sum;
	logic [eg_pkg::level_w-1:0] level_nx;
	logic [8:0]                 am_sc;
	logic [11:0]                att_sum;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++)
				set_d[i] <= '0;
		end else if (clk_en) begin
			set_d[0] <= {tl, am, ams, ams_en};
			for (int i = 1; i < 4; i++)
				set_d[i] <= set_d[i-1];
		end
	end

	assign {tl_d, am_d, ams_d, ams_en_d} = set_d[3];

	////////////////////////////////////////////////////////////////////////////
	// cycle one, level update
	always_comb begin
		case (rt2lv.rate[5:2])
			4'hd:       ar_delta = (rt2lv.level >> 3) + 1'b1;
			4'he, 4'hf: ar_delta = (rt2lv.level >> 2) + 1'b1;
			default:    ar_delta = (rt2lv.level >> 4) + 1'b1; // slow groups
		endcase
		dec_inc  = (rt2lv.rate[5:2] < 4'd12) ? 1 : 1 << (rt2lv.rate[5:2] - 4'd12); // 1,2,4,8
		dec_sum  = {1'b0, rt2lv.level} + dec_inc;
		level_nx = rt2lv.level;
		if (rt2lv.attack_off) begin
			level_nx = '0;
		end else if (rt2lv.phase == eg_pkg::ph_attack) begin
			if (rt2lv.step) begin
				if (rt2lv.rate >= 6'd62)
					level_nx = '0; // instant attack
				else
					level_nx = (ar_delta < rt2lv.level) ? rt2lv.level - ar_delta : '0;
			end
		end else if (rt2lv.step) begin
			level_nx = dec_sum[eg_pkg::level_w] ? eg_pkg::level_max
			                                    : dec_sum[eg_pkg::level_w-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			new_level <= eg_pkg::level_max;
			new_phase <= eg_pkg::ph_release;
		end else if (clk_en) begin
			new_level <= level_nx;
			new_phase <= rt2lv.phase;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// cycle two, total attenuation
	always_comb begin
		case (ams_d)
			2'd1:    am_sc = {2'b00, am_d};
			2'd2:    am_sc = {1'b0, am_d, 1'b0};
			2'd3:    am_sc = {am_d, 2'b00};
			default: am_sc = '0;
		endcase
		if (!ams_en_d)
			am_sc = '0;
		att_sum = 12'(new_level) + 12'({tl_d, 3'b000}) + 12'({am_sc, 1'b0});
	end

	always_ff @(posedge clk) begin
		if (rst)
			eg_level <= eg_pkg::level_max;
		else if (clk_en)
			eg_level <= (att_sum[11:10] != 2'b00) ? eg_pkg::level_max : att_sum[9:0];
	end

endmodule

// ==== envelope/eg_rate_step.sv ====
/*
	Envelope stage two.
	Cycle one scales the raw rate by keycode and key scale.
	Cycle two picks three envelope counter bits, looks up the
	step pattern and gates it with the counter bit change.
*/
`timescale 1ns/1ps

module eg_rate_step (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      clk_en,
	input  logic [4:0]                keycode,
	input  logic [1:0]                key_scale,
	input  logic [eg_pkg::cnt_w-1:0]  eg_cnt,
	input  logic                      ring_cnt_bit,
	eg_slot_if.dst                    ph2rt,
	eg_slot_if.src                    rt2lv,
	output logic                      cnt_bit
);

	logic [4:0]                 keycode_q;   // aligned with ph2rt
	logic [1:0]                 key_scale_q;
	logic [6:0]                 rate_sum;
	logic [eg_pkg::rate_w-1:0]  rate_q;
	logic [eg_pkg::level_w-1:0] level_q;
	logic [1:0]                 phase_q;
	logic                       aoff_q;
	logic [3:0]                 cnt_base;
	logic [3:0]                 cnt_start;
	logic [2:0]                 cnt_sel;
	logic [7:0]                 pat;
	logic                       step_nx;

	////////////////////////////////////////////////////////////////////////////
	// cycle one, effective rate
	assign rate_sum = {ph2rt.rate, 1'b0} + 7'(keycode_q >> (2'd3 - key_scale_q));

	always_ff @(posedge clk) begin
		if (rst) begin
			keycode_q   <= '0;
			key_scale_q <= '0;
			rate_q      <= '0;
			level_q     <= eg_pkg::level_max;
			phase_q     <= eg_pkg::ph_release;
			aoff_q      <= 1'b0;
		end else if (clk_en) begin
			keycode_q   <= keycode;
			key_scale_q <= key_scale;
			if (ph2rt.rate == '0)
				rate_q <= '0; // rate 0 never moves
			else
				rate_q <= rate_sum[6] ? 6'd63 : rate_sum[5:0];
			level_q <= ph2rt.level;
			phase_q <= ph2rt.phase;
			aoff_q  <= ph2rt.attack_off;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// cycle two, step decision
	always_comb begin
		cnt_base  = (phase_q == eg_pkg::ph_attack) ? 4'd11 : 4'd12; // decays one slower
		cnt_start = (cnt_base > rate_q[5:2]) ? cnt_base - rate_q[5:2] : 4'd0;
		cnt_sel   = 3'(eg_cnt >> cnt_start);
		if (rate_q[5:4] == 2'b11) begin
			if (rate_q[5:2] == 4'hf && phase_q == eg_pkg::ph_attack)
				pat = eg_pkg::step_pat_full;
			else
				pat = eg_pkg::step_pat_hi[rate_q[1:0]];
		end else begin
			if (rate_q[5:2] == 4'h0 && phase_q != eg_pkg::ph_attack)
				pat = eg_pkg::step_pat_slow;
			else
				pat = eg_pkg::step_pat_lo[rate_q[1:0]];
		end
		// only once per counter change
		step_nx = (rate_q[5:1] != 5'd0) && pat[cnt_sel] && (cnt_sel[0] != ring_cnt_bit);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rt2lv.level      <= eg_pkg::level_max;
			rt2lv.phase      <= eg_pkg::ph_release;
			rt2lv.rate       <= '0;
			rt2lv.step       <= 1'b0;
			rt2lv.attack_off <= 1'b0;
			cnt_bit          <= 1'b0;
		end else if (clk_en) begin
			rt2lv.level      <= level_q;
			rt2lv.phase      <= phase_q;
			rt2lv.rate       <= rate_q;
			rt2lv.step       <= step_nx;
			rt2lv.attack_off <= aoff_q;
			cnt_bit          <= cnt_sel[0]; // compared next pass
		end
	end

endmodule

// ==== envelope/eg_phase_sel.sv ====
/*
	Envelope stage one.
	Key edge detection against the key bit stored a pass ago,
	phase walk attack, decay1, decay2, release and raw rate pick.
	Raises the phase generator reset on key-on and at silence.
*/
`timescale 1ns/1ps

module eg_phase_sel (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       clk_en,
	input  logic                       keyon,
	input  logic [4:0]                 arate,
	input  logic [4:0]                 drate1,
	input  logic [4:0]                 drate2,
	input  logic [3:0]                 rrate,
	input  logic [3:0]                 sus_level,
	input  logic [eg_pkg::level_w-1:0] ring_level,
	input  logic [1:0]                 ring_phase,
	input  logic                       ring_key,
	output logic                       key_now,
	output logic                       phase_rst,
	eg_slot_if.src                     ph2rt
);

	logic       key_on_edge;
	logic       key_off_edge;
	logic [4:0] sus_top;  // compared with level[9:5]
	logic [1:0] phase_nx;
	logic [4:0] rate_nx;

	assign key_on_edge  = keyon & ~ring_key;
	assign key_off_edge = ~keyon & ring_key;
	assign sus_top      = (sus_level == 4'hf) ? 5'h1f : {1'b0, sus_level}; // 15 means bottom

	always_comb begin
		phase_nx = ring_phase;
		rate_nx  = arate;
		if (key_off_edge) begin
			phase_nx = eg_pkg::ph_release;
			rate_nx  = {rrate, 1'b1}; // release runs at 2r+1
		end else if (key_on_edge) begin
			phase_nx = eg_pkg::ph_attack;
			rate_nx  = arate;
		end else begin
			case (ring_phase)
				eg_pkg::ph_attack: begin
					if (ring_level == '0) begin // peak reached
						phase_nx = eg_pkg::ph_decay1;
						rate_nx  = drate1;
					end
				end
				eg_pkg::ph_decay1: begin
					if (ring_level[eg_pkg::level_w-1 -: 5] >= sus_top) begin
						phase_nx = eg_pkg::ph_decay2;
						rate_nx  = drate2;
					end else begin
						rate_nx = drate1;
					end
				end
				eg_pkg::ph_decay2: rate_nx = drate2;
				default:           rate_nx = {rrate, 1'b1};
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ph2rt.level      <= eg_pkg::level_max;
			ph2rt.phase      <= eg_pkg::ph_release;
			ph2rt.rate       <= '0;
			ph2rt.step       <= 1'b0;
			ph2rt.attack_off <= 1'b0;
			key_now          <= 1'b0;
			phase_rst        <= 1'b0;
		end else if (clk_en) begin
			ph2rt.level      <= ring_level;
			ph2rt.phase      <= phase_nx;
			ph2rt.rate       <= {1'b0, rate_nx};
			ph2rt.step       <= 1'b0; // decided in stage two
			ph2rt.attack_off <= key_on_edge && arate == 5'h1f;
			key_now          <= keyon; // back to this slot next pass
			// key-on or silent slot
			phase_rst <= key_on_edge | (ring_level == eg_pkg::level_max);
		end
	end

endmodule

// ==== hw/eg_timebase.sv ====
/*
	Envelope time base.
	Slot counter over the 24 operators, sample boundary strobe
	and the global envelope counter, one tick every 3 samples.
*/
`timescale 1ns/1ps

module eg_timebase (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      clk_en,
	output logic [eg_pkg::slot_w-1:0] slot,
	output logic                      sample_zero,
	output logic [eg_pkg::cnt_w-1:0]  eg_cnt
);

	logic [1:0] div3; // samples since last counter tick

	assign sample_zero = slot == eg_pkg::last_slot; // last slot of a sample

	always_ff @(posedge clk) begin
		if (rst) begin
			slot   <= '0;
			div3   <= '0;
			eg_cnt <= '0;
		end else if (clk_en) begin
			slot <= sample_zero ? '0 : slot + 1'b1;
			if (sample_zero) begin
				if (div3 == 2'd2) begin
					div3   <= '0;
					eg_cnt <= eg_cnt + 1'b1; // free running, wraps
				end else begin
					div3 <= div3 + 1'b1;
				end
			end
		end
	end

endmodule

// ==== common/eg_slot_if.sv ====
/*
	Slot data bundle between envelope stages.
	One slot per enabled cycle, no flow control.
*/
`timescale 1ns/1ps

interface eg_slot_if;

	logic [eg_pkg::level_w-1:0] level;      // stored attenuation
	logic [1:0]                 phase;      // envelope phase code
	logic [eg_pkg::rate_w-1:0]  rate;       // raw rate, then effective rate
	logic                       step;       // level moves this pass
	logic                       attack_off; // attack rate 31, jump to 0

	modport src (output level, phase, rate, step, attack_off);
	modport dst (input level, phase, rate, step, attack_off);

endinterface

// ==== common/eg_pkg.sv ====
/*
	Envelope generator shared definitions.
	Widths, phase codes, level limits, pipeline latencies
	and the step patterns used by the rate stage.
*/
package eg_pkg;

	// slot multiplexing
	localparam int num_slots = 24;
	localparam int slot_w    = 5;
	localparam logic [slot_w-1:0] last_slot = slot_w'(num_slots - 1); // sample boundary

	// data widths
	localparam int level_w = 10; // 0 is loudest
	localparam int rate_w  = 6;  // effective rate
	localparam int cnt_w   = 15; // global envelope counter
	localparam int tl_w    = 7;
	localparam int am_w    = 7;

	localparam logic [level_w-1:0] level_max = 10'h3ff; // silence

	// envelope phases
	localparam logic [1:0] ph_attack  = 2'd0;
	localparam logic [1:0] ph_decay1  = 2'd1;
	localparam logic [1:0] ph_decay2  = 2'd2;
	localparam logic [1:0] ph_release = 2'd3;

	////////////////////////////////////////////////////////////////////////////
	// step patterns, indexed by three counter bits
	localparam logic [3:0][7:0] step_pat_lo = {
		8'b11111110,	// 7 of 8
		8'b11101110,	// 6
		8'b11101010,	// 5
		8'b10101010		// 4
	};
	localparam logic [3:0][7:0] step_pat_hi = {
		8'b11101110,	// 6 of 8
		8'b10101010,	// 4
		8'b10001000,	// 2
		8'b00000000		// none
	};
	localparam logic [7:0] step_pat_full = 8'b11111111; // fastest attack
	localparam logic [7:0] step_pat_slow = 8'b11111110; // slowest decays

	// pipeline
	localparam int ring_depth = 20; // slots minus read to write-back depth
	localparam int eg_latency = 5;  // settings in to eg_level out

endpackage
